// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - logic/mem_pkg.sv
      - logic/ram_port_if.sv
      - logic/data_ram.sv
      - logic/data_mem.sv
      - logic/uart_loader.sv
      - logic/input_unit.sv
      - logic/output_unit.sv
      - logic/mem_stage_top.sv
  - target: test
    files:
      - test/mem_stage_checker.sv
      - test/mem_stage_tb.sv

// File: logic/data_mem.sv
`timescale 1ns/1ns
`default_nettype none

module data_mem #(
    parameter int RAM_ADDR_BITS = mem_pkg::DEFAULT_RAM_ADDR_BITS
) (
    input  wire logic                     clk,
    input  wire logic                     load_mode,       // loader owns the RAM
    input  wire logic                     no_op,           // bubble in ex_mem_reg
    input  wire mem_pkg::mem_ctrl_t       mem_control,     // {write, read}
    input  wire mem_pkg::word_t           mem_addr,        // byte address from alu
    input  wire mem_pkg::word_t           mem_store_data,  // store operand
    input  wire mem_pkg::word_t           input_data,      // keypad entry value
    input  wire logic                     load_we,         // loader word strobe
    input  wire logic [RAM_ADDR_BITS-1:0] load_addr,       // loader word index
    input  wire mem_pkg::word_t           load_data,       // assembled loader word
    output      mem_pkg::word_t           mem_read_data,   // to mem_wb_reg
    output      logic                     input_enable,    // keypad read, also stall request
    output      logic                     vga_write_enable,
    ram_port_if.master                    ram
);

    import mem_pkg::*;

    logic io_hit;                                    // address inside the IO window
    logic io_is_vga;                                 // type bit picks the device
    logic rd_sel_io;                                 // mux select aligned with ram rdata

    assign io_hit    = (mem_addr[IO_END_BIT:IO_START_BIT] == IO_HIGH_ADDR);
    assign io_is_vga = mem_addr[IO_TYPE_BIT];

    // keypad read does not look at no_op, same as the hazard unit expects
    assign input_enable     = io_hit & ~io_is_vga & mem_control[MEM_READ_BIT];
    assign vga_write_enable = io_hit & io_is_vga & mem_control[MEM_WRITE_BIT] & ~no_op;

    // RAM source select
    always_comb begin
        if (load_mode) begin
            ram.en    = 1'b1;                        // loader always enabled
            ram.we    = load_we;
            ram.addr  = load_addr;
            ram.wdata = load_data;
        end else begin
            ram.en    = ~no_op;                      // bubble freezes rdata
            ram.we    = mem_control[MEM_WRITE_BIT] & ~vga_write_enable;  // vga store skips ram
            ram.addr  = mem_addr[RAM_ADDR_BITS+1:2]; // byte to word index, io aliases
            ram.wdata = mem_store_data;
        end
    end

    // select sampled on the same edge as the ram output register
    always_ff @(negedge clk) begin
        rd_sel_io <= input_enable;
    end

    assign mem_read_data = rd_sel_io ? input_data : ram.rdata;

endmodule

`default_nettype wire

// File: logic/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int RAM_ADDR_BITS = mem_pkg::DEFAULT_RAM_ADDR_BITS
) (
    input  wire logic clk,
    input  wire logic rst_n,
    ram_port_if.slave ram
);

    import mem_pkg::*;

    localparam int DEPTH = 1 << RAM_ADDR_BITS;       // words in the array

    word_t mem [DEPTH];                              // storage, no reset
    word_t rdata_q;                                  // output register

    // Both processes run on the falling edge so that an access presented
    // at a rising edge is finished half a cycle later, ready for the
    // mem_wb register at the next rising edge.

    always_ff @(negedge clk) begin
        if (ram.en && ram.we) begin                  // enable gates the write too
            mem[ram.addr] <= ram.wdata;
        end
    end

    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (ram.en) begin                   // disabled port holds last word
            rdata_q <= mem[ram.addr];                // old word on a same-edge write
        end
    end

    assign ram.rdata = rdata_q;

endmodule

`default_nettype wire

// File: logic/input_unit.sv
`timescale 1ns/1ns
`default_nettype none

module input_unit (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            key_valid,     // one pulse per key press
    input  wire mem_pkg::digit_t key_digit,     // hex value of the key
    input  wire logic            input_enable,  // cpu reads the keypad this cycle
    output      mem_pkg::word_t  input_data     // current entry value
);

    import mem_pkg::*;

    word_t entry;                               // number typed so far

    // Each key shifts the number one hex digit to the left. A read hands
    // the whole number to the CPU and starts a new one, so a key that
    // arrives together with the read becomes the first digit of the next.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry <= '0;
        end else if (input_enable) begin
            if (key_valid) begin
                entry <= word_t'(key_digit);    // read got the old value
            end else begin
                entry <= '0;                    // consumed
            end
        end else if (key_valid) begin
            entry <= {entry[WORD_BITS-DIGIT_BITS-1:0], key_digit};
        end
    end

    assign input_data = entry;                  // valid through the read cycle

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int WORD_BITS  = 32;                  // datapath and address width
    localparam int BYTE_BITS  = 8;                   // loader byte width
    localparam int DIGIT_BITS = 4;                   // one hex key

    typedef logic [WORD_BITS-1:0]  word_t;           // data / address word
    typedef logic [BYTE_BITS-1:0]  byte_t;           // received loader byte
    typedef logic [DIGIT_BITS-1:0] digit_t;          // keypad digit
    typedef logic [1:0]            mem_ctrl_t;       // {write, read} from ex_mem_reg

    // bit positions inside mem_ctrl_t
    localparam int MEM_READ_BIT  = 0;
    localparam int MEM_WRITE_BIT = 1;

    // IO window is the top 1 KB of the address space
    localparam int IO_START_BIT = 10;
    localparam int IO_END_BIT   = 31;
    localparam logic [IO_END_BIT-IO_START_BIT:0] IO_HIGH_ADDR = '1;   // all-ones prefix

    localparam int IO_TYPE_BIT = 4;                  // 0 keypad, 1 vga

    localparam word_t KEYPAD_ADDR = 32'hFFFF_FC60;   // keypad entry register
    localparam word_t VGA_ADDR    = 32'hFFFF_FC70;   // vga display register

    localparam int DEFAULT_RAM_ADDR_BITS = 14;       // 16K words, 64 KB

endpackage

`default_nettype wire

// File: logic/mem_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_top #(
    parameter int RAM_ADDR_BITS = mem_pkg::DEFAULT_RAM_ADDR_BITS
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               no_op,           // pipeline bubble
    input  wire mem_pkg::mem_ctrl_t mem_control,     // {write, read}
    input  wire mem_pkg::word_t     mem_addr,        // byte address
    input  wire mem_pkg::word_t     mem_store_data,  // store operand
    input  wire logic               key_valid,       // keypad strobe
    input  wire mem_pkg::digit_t    key_digit,       // keypad value
    input  wire logic               load_mode,       // loader owns the RAM
    input  wire logic               byte_valid,      // loader byte strobe
    input  wire mem_pkg::byte_t     rx_byte,         // loader byte
    output      mem_pkg::word_t     mem_read_data,   // to mem_wb_reg
    output      logic               input_enable,    // keypad read / stall
    output      mem_pkg::word_t     vga_value        // display register
);

    import mem_pkg::*;

    word_t                    input_data;            // keypad entry to decode
    logic                     vga_write_enable;      // decode to vga register
    logic                     load_we;               // loader strobes
    logic [RAM_ADDR_BITS-1:0] load_addr;
    word_t                    load_data;

    ram_port_if #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) ram_port ();

    data_mem #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) i_data_mem (
        .clk              (clk),
        .load_mode        (load_mode),
        .no_op            (no_op),
        .mem_control      (mem_control),
        .mem_addr         (mem_addr),
        .mem_store_data   (mem_store_data),
        .input_data       (input_data),
        .load_we          (load_we),
        .load_addr        (load_addr),
        .load_data        (load_data),
        .mem_read_data    (mem_read_data),
        .input_enable     (input_enable),
        .vga_write_enable (vga_write_enable),
        .ram              (ram_port.master)
    );

    data_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) i_data_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .ram   (ram_port.slave)
    );

    uart_loader #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) i_uart_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_mode  (load_mode),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    input_unit i_input_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key_digit    (key_digit),
        .input_enable (input_enable),
        .input_data   (input_data)
    );

    output_unit i_output_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .vga_write_enable (vga_write_enable),
        .mem_store_data   (mem_store_data),
        .vga_value        (vga_value)
    );

endmodule

`default_nettype wire

// File: logic/output_unit.sv
`timescale 1ns/1ns
`default_nettype none

module output_unit (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           vga_write_enable,  // store to the vga address
    input  wire mem_pkg::word_t mem_store_data,    // value to display
    output      mem_pkg::word_t vga_value          // held for the display
);

    import mem_pkg::*;

    word_t display_q;                              // display register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            display_q <= '0;                       // blank screen value
        end else if (vga_write_enable) begin
            display_q <= mem_store_data;           // taken at end of the store cycle
        end
    end

    assign vga_value = display_q;                  // unchanged until next store

endmodule

`default_nettype wire

// File: logic/ram_port_if.sv
`timescale 1ns/1ns
`default_nettype none

// one word-wide port of the data RAM
interface ram_port_if #(
    parameter int RAM_ADDR_BITS = mem_pkg::DEFAULT_RAM_ADDR_BITS
) ();

    import mem_pkg::*;

    logic                     en;                    // gates read and write
    logic                     we;                    // write enable
    logic [RAM_ADDR_BITS-1:0] addr;                  // word index
    word_t                    wdata;                 // store word
    word_t                    rdata;                 // registered read word

    modport master (                                 // access side, data_mem
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (                                  // storage side, data_ram
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: logic/uart_loader.sv
`timescale 1ns/1ns
`default_nettype none

module uart_loader #(
    parameter int RAM_ADDR_BITS = mem_pkg::DEFAULT_RAM_ADDR_BITS
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     load_mode,   // level, loader active
    input  wire logic                     byte_valid,  // one pulse per received byte
    input  wire mem_pkg::byte_t           rx_byte,     // byte already deframed
    output      logic                     load_we,     // one cycle per full word
    output      logic [RAM_ADDR_BITS-1:0] load_addr,   // word index, from 0 up
    output      mem_pkg::word_t           load_data    // assembled word
);

    import mem_pkg::*;

    logic [1:0] byte_cnt;                            // bytes held in shift_word
    word_t      shift_word;                          // new bytes enter at the top
    logic       word_done;                           // fourth byte this cycle

    assign word_done = byte_valid & (byte_cnt == 2'd3);

    // shifting right puts the first byte of a word in bits 7..0
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            shift_word <= {rx_byte, shift_word[WORD_BITS-1:BYTE_BITS]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
        end else if (!load_mode) begin
            byte_cnt <= '0;                          // restart word on next load
        end else if (byte_valid) begin
            byte_cnt <= byte_cnt + 2'd1;             // wraps after the fourth byte
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_we <= 1'b0;
        end else begin
            load_we <= load_mode & word_done;        // write lands at next falling edge
        end
    end

    // address moves on only after the word has been written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_addr <= '0;
        end else if (!load_mode) begin
            load_addr <= '0;
        end else if (load_we) begin
            load_addr <= load_addr + 1'b1;
        end
    end

    assign load_data = shift_word;                   // complete while load_we is high

endmodule

`default_nettype wire

// File: mem_stage.f
logic/mem_pkg.sv
logic/ram_port_if.sv
logic/data_ram.sv
logic/data_mem.sv
logic/uart_loader.sv
logic/input_unit.sv
logic/output_unit.sv
logic/mem_stage_top.sv
test/mem_stage_checker.sv
test/mem_stage_tb.sv

// File: test/mem_stage_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_checker #(
    parameter int RAM_ADDR_BITS = mem_pkg::DEFAULT_RAM_ADDR_BITS
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               no_op,
    input  wire mem_pkg::mem_ctrl_t mem_control,
    input  wire mem_pkg::word_t     mem_addr,
    input  wire mem_pkg::word_t     mem_store_data,
    input  wire logic               key_valid,
    input  wire mem_pkg::digit_t    key_digit,
    input  wire logic               load_mode,
    input  wire logic               byte_valid,
    input  wire mem_pkg::byte_t     rx_byte,
    input  wire mem_pkg::word_t     mem_read_data,
    input  wire logic               input_enable,
    input  wire mem_pkg::word_t     vga_value,
    output int                      read_errors,
    output int                      enable_errors,
    output int                      vga_errors,
    output int                      check_count
);

    import mem_pkg::*;

    localparam int DEPTH = 1 << RAM_ADDR_BITS;

    word_t                    ram_m [DEPTH];     // shadow RAM, unwritten words stay X
    word_t                    rdata_m;           // shadow RAM output register
    word_t                    entry_m;           // shadow keypad entry
    word_t                    vga_m;             // shadow display value
    byte_t                    part_m [4];        // bytes of the word being loaded
    int                       byte_cnt_m;
    logic                     load_pend_m;       // full word waits for its write cycle
    word_t                    load_word_m;
    logic [RAM_ADDR_BITS-1:0] load_addr_m;       // next loader word index

    // keypad read wins the mux, a disabled RAM keeps its last word
    function automatic word_t predict_read_data(input logic                     kp_read,
                                                input logic                     ram_en,
                                                input logic [RAM_ADDR_BITS-1:0] idx);
        if (kp_read) begin
            return entry_m;
        end else if (ram_en) begin
            return ram_m[idx];                   // old word even if written this cycle
        end
        return rdata_m;
    endfunction

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("[ERROR] %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
    endtask

    // inputs seen here are the ones of the cycle that just closed
    always @(posedge clk or negedge rst_n) begin : compare
        logic                     io_hit;
        logic                     kp_read;
        logic                     vga_store;
        logic                     ram_en;
        logic                     ram_we;
        logic [RAM_ADDR_BITS-1:0] ram_idx;
        word_t                    ram_wdata;
        word_t                    read_exp;
        if (!rst_n) begin
            rdata_m       = '0;
            entry_m       = '0;
            vga_m         = '0;
            byte_cnt_m    = 0;
            load_pend_m   = 1'b0;
            load_addr_m   = '0;
            read_errors   = 0;
            enable_errors = 0;
            vga_errors    = 0;
            check_count   = 0;
        end else begin
            io_hit    = (mem_addr[IO_END_BIT:IO_START_BIT] == IO_HIGH_ADDR);
            kp_read   = io_hit & ~mem_addr[IO_TYPE_BIT] & mem_control[MEM_READ_BIT];
            vga_store = io_hit & mem_addr[IO_TYPE_BIT] & mem_control[MEM_WRITE_BIT] & ~no_op;
            if (load_mode) begin                 // loader owns the port
                ram_en    = 1'b1;
                ram_we    = load_pend_m;
                ram_idx   = load_addr_m;
                ram_wdata = load_word_m;
            end else begin
                ram_en    = ~no_op;
                ram_we    = ~no_op & mem_control[MEM_WRITE_BIT] & ~vga_store;
                ram_idx   = mem_addr[RAM_ADDR_BITS+1:2];
                ram_wdata = mem_store_data;
            end
            read_exp = predict_read_data(kp_read, ram_en, ram_idx);

            if (input_enable !== kp_read) begin
                report_mismatch("input_enable", word_t'(kp_read), word_t'(input_enable));
                enable_errors++;
            end
            if (vga_value !== vga_m) begin   // register still holds the older store
                report_mismatch("vga_value", vga_m, vga_value);
                vga_errors++;
            end
            if (!load_mode && (mem_control[MEM_READ_BIT] || no_op)) begin
                if (mem_read_data !== read_exp) begin
                    report_mismatch("mem_read_data", read_exp, mem_read_data);
                    read_errors++;
                end
                check_count++;
            end
            check_count += 2;

            if (ram_en) begin
                rdata_m = ram_m[ram_idx];
                if (ram_we) begin
                    ram_m[ram_idx] = ram_wdata;
                end
            end
            if (vga_store) begin
                vga_m = mem_store_data;
            end
            if (kp_read) begin
                entry_m = key_valid ? word_t'(key_digit) : '0;  // coinciding key starts anew
            end else if (key_valid) begin
                entry_m = {entry_m[WORD_BITS-DIGIT_BITS-1:0], key_digit};
            end

            if (!load_mode) begin
                byte_cnt_m  = 0;
                load_pend_m = 1'b0;
                load_addr_m = '0;
            end else begin
                if (load_pend_m) begin
                    load_addr_m = load_addr_m + 1'b1;
                end
                load_pend_m = 1'b0;
                if (byte_valid) begin
                    part_m[byte_cnt_m] = rx_byte;
                    if (byte_cnt_m == 3) begin   // first byte lands in bits 7..0
                        load_word_m = {part_m[3], part_m[2], part_m[1], part_m[0]};
                        load_pend_m = 1'b1;
                        byte_cnt_m  = 0;
                    end else begin
                        byte_cnt_m++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/mem_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_tb;

    import mem_pkg::*;

    localparam int    RAM_ADDR_BITS = DEFAULT_RAM_ADDR_BITS;
    localparam int    HALF_PERIOD   = 20;                       // 40 ns clock
    localparam int    RESET_CYCLES  = 3;
    localparam int    LOAD_BYTES    = 32;
    localparam int    RAM_OPS       = 40;
    localparam int    POOL_SIZE     = 8;                        // addresses the ram ops reuse
    localparam int    KEY_ROUNDS    = 5;
    localparam int    MAX_KEYS      = 8;
    localparam word_t WORD_MASK     = word_t'(((1 << RAM_ADDR_BITS) - 1) << 2);

    localparam mem_ctrl_t CTRL_READ  = 2'b01;
    localparam mem_ctrl_t CTRL_WRITE = 2'b10;
    localparam mem_ctrl_t CTRL_RW    = 2'b11;

    // upper bound of cycles per sequence
    localparam int RESET_LEN = RESET_CYCLES + 3;
    localparam int LOAD_LEN  = 2 * LOAD_BYTES + 16;
    localparam int RAM_LEN   = 2 * POOL_SIZE + RAM_OPS + 4;
    localparam int VGA_LEN   = 8;
    localparam int KEY_LEN   = KEY_ROUNDS * (MAX_KEYS + 2) + 2;
    localparam int NOOP_LEN  = 8;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_LEN + LOAD_LEN + RAM_LEN + VGA_LEN + KEY_LEN + NOOP_LEN);

    logic      clk;
    logic      rst_n;
    logic      no_op;
    mem_ctrl_t mem_control;
    word_t     mem_addr;
    word_t     mem_store_data;
    logic      key_valid;
    digit_t    key_digit;
    logic      load_mode;
    logic      byte_valid;
    byte_t     rx_byte;
    word_t     mem_read_data;
    logic      input_enable;
    word_t     vga_value;
    int        read_errors;
    int        enable_errors;
    int        vga_errors;
    int        check_count;
    int        seed;
    int        cycle_count = 0;

    mem_stage_top #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) i_mem_stage_top (.*);

    mem_stage_checker #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) i_mem_stage_checker (.*);

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, stimulus did not finish", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic clear_inputs();                             // idle bus, no strobes
        no_op          <= 1'b0;
        mem_control    <= 2'b00;
        mem_addr       <= '0;
        mem_store_data <= '0;
        key_valid      <= 1'b0;
        byte_valid     <= 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        clear_inputs();
    endtask

    task automatic cpu_access(input logic nop, input mem_ctrl_t ctrl, input word_t addr,
                              input word_t data);
        @(posedge clk);
        clear_inputs();
        no_op          <= nop;
        mem_control    <= ctrl;
        mem_addr       <= addr;
        mem_store_data <= data;
    endtask

    task automatic press_key(input digit_t digit);
        @(posedge clk);
        clear_inputs();
        key_valid <= 1'b1;
        key_digit <= digit;
    endtask

    task automatic read_keypad(input logic with_key, input digit_t digit);
        @(posedge clk);
        clear_inputs();
        mem_control <= CTRL_READ;
        mem_addr    <= KEYPAD_ADDR;
        key_valid   <= with_key;                               // key in the read cycle
        key_digit   <= digit;
    endtask

    task automatic send_byte(input byte_t value);
        @(posedge clk);
        clear_inputs();
        byte_valid <= 1'b1;
        rx_byte    <= value;
    endtask

    task automatic set_load_mode(input logic level);
        @(posedge clk);
        clear_inputs();
        load_mode <= level;
    endtask

    initial begin : stimulus
        word_t     pool [POOL_SIZE];
        mem_ctrl_t op_ctrl;
        int        n_keys;
        seed           = 50;
        clk            = 1'b0;
        rst_n          = 1'b0;
        no_op          = 1'b0;
        mem_control    = 2'b00;
        mem_addr       = '0;
        mem_store_data = '0;
        key_valid      = 1'b0;
        key_digit      = '0;
        load_mode      = 1'b0;
        byte_valid     = 1'b0;
        rx_byte        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        read_keypad(1'b0, 4'h0);                               // empty entry after reset
        idle_cycle();

        set_load_mode(1'b1);
        for (int i = 0; i < LOAD_BYTES; i++) begin
            send_byte(byte_t'($random(seed)));
            idle_cycle();
        end
        idle_cycle();                                          // last word written
        set_load_mode(1'b0);
        for (int i = 0; i < LOAD_BYTES / 4; i++) begin
            cpu_access(1'b0, CTRL_READ, word_t'(i) << 2, '0);
        end

        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = word_t'($random(seed)) & WORD_MASK;
            cpu_access(1'b0, CTRL_WRITE, pool[i], word_t'($random(seed)));
        end
        cpu_access(1'b0, CTRL_RW, pool[0], word_t'($random(seed)));  // old word back
        cpu_access(1'b0, CTRL_READ, pool[0], '0);
        for (int i = 0; i < RAM_OPS; i++) begin
            op_ctrl = mem_ctrl_t'(1 + $unsigned($random(seed)) % 3);
            cpu_access(1'b0, op_ctrl, pool[$unsigned($random(seed)) % POOL_SIZE],
                       word_t'($random(seed)));
        end

        cpu_access(1'b0, CTRL_WRITE, VGA_ADDR & WORD_MASK, word_t'($random(seed)));
        cpu_access(1'b0, CTRL_WRITE, VGA_ADDR, word_t'($random(seed)));
        cpu_access(1'b0, CTRL_READ, VGA_ADDR & WORD_MASK, '0);  // alias untouched
        cpu_access(1'b0, CTRL_READ, VGA_ADDR, '0);
        cpu_access(1'b0, CTRL_WRITE, KEYPAD_ADDR, word_t'($random(seed)));
        cpu_access(1'b0, CTRL_READ, KEYPAD_ADDR & WORD_MASK, '0);
        idle_cycle();

        for (int r = 0; r < KEY_ROUNDS; r++) begin
            n_keys = 1 + $unsigned($random(seed)) % MAX_KEYS;
            for (int j = 0; j < n_keys; j++) begin
                press_key(digit_t'($random(seed)));
            end
            read_keypad(r == 2, digit_t'($random(seed)));
            idle_cycle();
        end
        read_keypad(1'b0, 4'h0);                               // cleared by the last read
        idle_cycle();

        cpu_access(1'b0, CTRL_READ, pool[2], '0);              // rdata not the pool[1] word
        cpu_access(1'b1, CTRL_RW, pool[1], word_t'($random(seed)));    // dropped write
        cpu_access(1'b1, CTRL_WRITE, VGA_ADDR, word_t'($random(seed)));
        cpu_access(1'b0, CTRL_READ, pool[1], '0);
        idle_cycle();
        idle_cycle();
        @(negedge clk);                                        // checker done with last edge

        $display("checks %0d, errors: mem_read_data %0d, input_enable %0d, vga_value %0d",
                 check_count, read_errors, enable_errors, vga_errors);
        if (read_errors + enable_errors + vga_errors == 0 && check_count > 0) begin
            $display("=== PASS ===");
        end else begin
            if (check_count == 0) begin
                $display("no comparisons were made by the checker");
            end
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
